// ==== source/core_pkg.sv ====
`default_nettype none

package core_pkg;

  localparam int xlen = 32;
  localparam int reg_count = 32;
  localparam int inst_queue_depth = 4;

  localparam int reg_addr_w = $clog2(reg_count);
  localparam int queue_ptr_w = $clog2(inst_queue_depth);
  localparam int shamt_w = $clog2(xlen);

  // major opcodes, inst[6:0]
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_opimm  = 7'b0010011;
  localparam logic [6:0] op_op     = 7'b0110011;

  // branch conditions are funct3 as encoded
  localparam logic [2:0] cond_beq  = 3'b000;
  localparam logic [2:0] cond_bne  = 3'b001;
  localparam logic [2:0] cond_blt  = 3'b100;
  localparam logic [2:0] cond_bge  = 3'b101;
  localparam logic [2:0] cond_bltu = 3'b110;
  localparam logic [2:0] cond_bgeu = 3'b111;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_t;

  typedef enum logic [1:0] {mem_none, mem_load, mem_store} mem_kind_t;

  typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_t;

  typedef enum logic [1:0] {ctrl_none, ctrl_branch, ctrl_jal, ctrl_jalr} ctrl_kind_t;

endpackage

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  wire logic [core_pkg::xlen-1:0] a,
  input  wire logic [core_pkg::xlen-1:0] b,
  input  wire core_pkg::alu_op_t op,
  output logic [core_pkg::xlen-1:0] result
);

  logic [core_pkg::shamt_w-1:0] shamt;

  assign shamt = b[core_pkg::shamt_w-1:0];

  always_comb begin
    case (op)
      core_pkg::alu_add:  result = a + b;
      core_pkg::alu_sub:  result = a - b;
      core_pkg::alu_sll:  result = a << shamt;
      core_pkg::alu_slt:  result = {{(core_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
      core_pkg::alu_sltu: result = {{(core_pkg::xlen-1){1'b0}}, a < b};
      core_pkg::alu_xor:  result = a ^ b;
      core_pkg::alu_srl:  result = a >> shamt;
      core_pkg::alu_sra:  result = $unsigned($signed(a) >>> shamt);
      core_pkg::alu_or:   result = a | b;
      core_pkg::alu_and:  result = a & b;
      default:            result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/decode_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_unit (
  input  wire logic clock,
  input  wire logic reset,
  input  wire logic inst_valid,
  input  wire logic [core_pkg::xlen-1:0] inst_pc,
  input  wire logic [31:0] inst_word,
  output logic credit_return,
  output logic [core_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [core_pkg::reg_addr_w-1:0] rs2_addr,
  input  wire logic [core_pkg::xlen-1:0] rs1_data,
  input  wire logic [core_pkg::xlen-1:0] rs2_data,
  input  wire logic [core_pkg::reg_addr_w-1:0] busy_rd,
  input  wire logic [core_pkg::reg_addr_w-1:0] pending_rd,
  output logic issue_valid,
  input  wire logic issue_ready,
  output logic [core_pkg::xlen-1:0] pc,
  output logic [core_pkg::xlen-1:0] op_a,
  output logic [core_pkg::xlen-1:0] op_b,
  output logic [core_pkg::xlen-1:0] store_data,
  output logic [core_pkg::xlen-1:0] imm,
  output core_pkg::alu_op_t alu_op,
  output logic alu_src_pc,
  output logic alu_src_imm,
  output core_pkg::mem_kind_t mem_kind,
  output core_pkg::mem_size_t mem_size,
  output logic mem_signed,
  output core_pkg::ctrl_kind_t ctrl_kind,
  output logic [2:0] branch_cond,
  output logic [core_pkg::reg_addr_w-1:0] rd,
  input  wire logic resolve_valid,
  input  wire logic resolve_taken,
  input  wire logic [core_pkg::xlen-1:0] resolve_target
);

  logic [core_pkg::xlen-1:0] q_pc [core_pkg::inst_queue_depth];
  logic [31:0] q_word [core_pkg::inst_queue_depth];
  logic [core_pkg::queue_ptr_w-1:0] wr_ptr, rd_ptr;
  logic [core_pkg::queue_ptr_w:0] count;
  logic [core_pkg::xlen-1:0] exp_pc;
  logic ctrl_pending; // control issued, not yet resolved
  logic [31:0] word;
  logic [2:0] funct3;
  logic head_valid, hazard, drop, issue_fire, pop;
  logic [core_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  function automatic core_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000: arith_op = alt ? core_pkg::alu_sub : core_pkg::alu_add;
      3'b001: arith_op = core_pkg::alu_sll;
      3'b010: arith_op = core_pkg::alu_slt;
      3'b011: arith_op = core_pkg::alu_sltu;
      3'b100: arith_op = core_pkg::alu_xor;
      3'b101: arith_op = alt ? core_pkg::alu_sra : core_pkg::alu_srl;
      3'b110: arith_op = core_pkg::alu_or;
      default: arith_op = core_pkg::alu_and;
    endcase
  endfunction

  assign word = q_word[rd_ptr];
  assign pc = q_pc[rd_ptr];
  assign funct3 = word[14:12];
  assign rs1_addr = word[19:15];
  assign rs2_addr = word[24:20];

  assign imm_i = {{(core_pkg::xlen-12){word[31]}}, word[31:20]};
  assign imm_s = {{(core_pkg::xlen-12){word[31]}}, word[31:25], word[11:7]};
  assign imm_b = {{(core_pkg::xlen-13){word[31]}}, word[31], word[7], word[30:25],
                  word[11:8], 1'b0};
  assign imm_u = {word[31:12], 12'b0};
  assign imm_j = {{(core_pkg::xlen-21){word[31]}}, word[31], word[19:12], word[20],
                  word[30:21], 1'b0};

  // operands in flight ahead of us block issue
  assign hazard = (rs1_addr != '0 && (rs1_addr == busy_rd || rs1_addr == pending_rd)) ||
                  (rs2_addr != '0 && (rs2_addr == busy_rd || rs2_addr == pending_rd));

  assign head_valid = count != '0;
  assign issue_valid = head_valid && !ctrl_pending && pc == exp_pc && !hazard;
  assign drop = head_valid && !ctrl_pending && pc != exp_pc; // off-path pair
  assign issue_fire = issue_valid && issue_ready;
  assign pop = drop || issue_fire;

  always_comb begin
    op_a = rs1_data;
    op_b = rs2_data;
    store_data = rs2_data;
    imm = imm_i;
    alu_op = core_pkg::alu_add;
    alu_src_pc = 1'b0;
    alu_src_imm = 1'b1;
    mem_kind = core_pkg::mem_none;
    mem_size = core_pkg::mem_size_t'(funct3[1:0]);
    mem_signed = ~funct3[2];
    ctrl_kind = core_pkg::ctrl_none;
    branch_cond = funct3;
    rd = word[11:7];
    case (word[6:0])
      core_pkg::op_lui: begin
        op_a = '0;
        imm = imm_u;
      end
      core_pkg::op_auipc: begin
        alu_src_pc = 1'b1;
        imm = imm_u;
      end
      core_pkg::op_jal: begin
        alu_src_pc = 1'b1;
        imm = imm_j;
        ctrl_kind = core_pkg::ctrl_jal;
      end
      core_pkg::op_jalr: ctrl_kind = core_pkg::ctrl_jalr;
      core_pkg::op_branch: begin
        alu_src_pc = 1'b1; // alu forms the target
        imm = imm_b;
        ctrl_kind = core_pkg::ctrl_branch;
        rd = '0;
      end
      core_pkg::op_load: mem_kind = core_pkg::mem_load;
      core_pkg::op_store: begin
        mem_kind = core_pkg::mem_store;
        imm = imm_s;
        rd = '0;
      end
      core_pkg::op_opimm: alu_op = arith_op(funct3, funct3 == 3'b101 && word[30]);
      core_pkg::op_op: begin
        alu_src_imm = 1'b0;
        alu_op = arith_op(funct3, word[30]);
      end
      default: rd = '0; // unknown opcode retires as a nop
    endcase
  end

  always_ff @(posedge clock) begin
    if (inst_valid) begin
      q_pc[wr_ptr] <= inst_pc;
      q_word[wr_ptr] <= inst_word;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      exp_pc <= '0;
      ctrl_pending <= 1'b0;
      credit_return <= 1'b0;
    end else begin
      credit_return <= pop;
      if (inst_valid) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (inst_valid ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
      if (issue_fire) begin
        exp_pc <= pc + 'd4;
        ctrl_pending <= ctrl_kind != core_pkg::ctrl_none;
      end else if (resolve_valid) begin
        ctrl_pending <= 1'b0;
        if (resolve_taken) exp_pc <= resolve_target;
      end
    end
  end

  // credits held by the source must keep the queue from overflowing
  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    inst_valid |-> count != core_pkg::inst_queue_depth);

  // a resolve pulse answers the control instruction still unresolved here
  a_resolve_pending: assert property (@(posedge clock) disable iff (reset)
    resolve_valid |-> ctrl_pending);

endmodule

`default_nettype wire

// ==== source/execute_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
  input  wire logic clock,
  input  wire logic reset,
  input  wire logic issue_valid,
  output logic issue_ready,
  input  wire logic [core_pkg::xlen-1:0] pc,
  input  wire logic [core_pkg::xlen-1:0] op_a,
  input  wire logic [core_pkg::xlen-1:0] op_b,
  input  wire logic [core_pkg::xlen-1:0] store_data,
  input  wire logic [core_pkg::xlen-1:0] imm,
  input  wire core_pkg::alu_op_t alu_op,
  input  wire logic alu_src_pc,
  input  wire logic alu_src_imm,
  input  wire core_pkg::mem_kind_t mem_kind,
  input  wire core_pkg::mem_size_t mem_size,
  input  wire logic mem_signed,
  input  wire core_pkg::ctrl_kind_t ctrl_kind,
  input  wire logic [2:0] branch_cond,
  input  wire logic [core_pkg::reg_addr_w-1:0] rd,
  output logic [core_pkg::reg_addr_w-1:0] busy_rd,
  output logic resolve_valid,
  output logic resolve_taken,
  output logic [core_pkg::xlen-1:0] resolve_target,
  output logic done_valid,
  input  wire logic done_ready,
  output logic [core_pkg::xlen-1:0] done_pc,
  output logic [core_pkg::reg_addr_w-1:0] done_rd,
  output logic [core_pkg::xlen-1:0] done_data,
  output logic mem_req,
  input  wire logic mem_gnt,
  output logic mem_write,
  output logic [core_pkg::xlen-1:0] mem_addr,
  output logic [core_pkg::xlen-1:0] mem_wdata,
  output logic [core_pkg::xlen/8-1:0] mem_wstrb,
  input  wire logic mem_resp_valid,
  input  wire logic [core_pkg::xlen-1:0] mem_rdata
);

  typedef enum logic [1:0] {st_idle, st_request, st_response, st_hold} state_t;

  state_t state;
  logic [core_pkg::xlen-1:0] cur_pc, cur_a, cur_b, cur_sdata, cur_imm, load_val;
  core_pkg::alu_op_t cur_alu_op, cmp_op;
  logic cur_src_pc, cur_src_imm, cur_signed;
  core_pkg::mem_kind_t cur_mem_kind;
  core_pkg::mem_size_t cur_size;
  core_pkg::ctrl_kind_t cur_ctrl;
  logic [2:0] cur_cond;
  logic [core_pkg::reg_addr_w-1:0] cur_rd;
  logic [core_pkg::xlen-1:0] alu_res, cmp_res, load_raw, load_ext;
  logic [1:0] byte_off;
  logic [core_pkg::xlen/8-1:0] strb_base;
  logic accept, cmp_zero;

  assign accept = issue_valid && issue_ready;
  assign issue_ready = state == st_idle || (state == st_hold && done_ready);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_request: if (mem_gnt) state <= st_response;
        st_response: if (mem_resp_valid) state <= st_hold;
        st_hold: if (done_ready) state <= st_idle;
        default: ;
      endcase
      if (accept) state <= (mem_kind == core_pkg::mem_none) ? st_hold : st_request;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      cur_pc <= pc;
      cur_a <= op_a;
      cur_b <= op_b;
      cur_sdata <= store_data;
      cur_imm <= imm;
      cur_alu_op <= alu_op;
      cur_src_pc <= alu_src_pc;
      cur_src_imm <= alu_src_imm;
      cur_mem_kind <= mem_kind;
      cur_size <= mem_size;
      cur_signed <= mem_signed;
      cur_ctrl <= ctrl_kind;
      cur_cond <= branch_cond;
      cur_rd <= rd;
    end
    if (state == st_response && mem_resp_valid) load_val <= load_ext;
  end

  // result, address or jump target
  alu u_alu (
    .a(cur_src_pc ? cur_pc : cur_a),
    .b(cur_src_imm ? cur_imm : cur_b),
    .op(cur_alu_op),
    .result(alu_res)
  );

  always_comb begin
    case (cur_cond)
      core_pkg::cond_blt, core_pkg::cond_bge: cmp_op = core_pkg::alu_slt;
      core_pkg::cond_bltu, core_pkg::cond_bgeu: cmp_op = core_pkg::alu_sltu;
      default: cmp_op = core_pkg::alu_sub; // beq, bne
    endcase
  end

  alu u_cmp (.a(cur_a), .b(cur_b), .op(cmp_op), .result(cmp_res));

  assign cmp_zero = cmp_res == '0;

  always_comb begin
    case (cur_cond)
      core_pkg::cond_beq: resolve_taken = cmp_zero;
      core_pkg::cond_bne: resolve_taken = !cmp_zero;
      core_pkg::cond_blt, core_pkg::cond_bltu: resolve_taken = cmp_res[0];
      core_pkg::cond_bge, core_pkg::cond_bgeu: resolve_taken = !cmp_res[0];
      default: resolve_taken = 1'b0;
    endcase
    if (cur_ctrl == core_pkg::ctrl_jal || cur_ctrl == core_pkg::ctrl_jalr) resolve_taken = 1'b1;
  end

  assign resolve_target = (cur_ctrl == core_pkg::ctrl_jalr) ? {alu_res[core_pkg::xlen-1:1], 1'b0}
                                                            : alu_res;
  assign resolve_valid = done_valid && done_ready && cur_ctrl != core_pkg::ctrl_none;

  // byte lanes on a word-aligned bus
  assign byte_off = alu_res[1:0];
  assign mem_req = state == st_request;
  assign mem_write = cur_mem_kind == core_pkg::mem_store;
  assign mem_addr = {alu_res[core_pkg::xlen-1:2], 2'b00};
  assign mem_wdata = cur_sdata << {byte_off, 3'b000};

  always_comb begin
    case (cur_size)
      core_pkg::size_byte: strb_base = 4'b0001;
      core_pkg::size_half: strb_base = 4'b0011;
      default: strb_base = 4'b1111;
    endcase
  end

  assign mem_wstrb = mem_write ? strb_base << byte_off : '0;

  assign load_raw = mem_rdata >> {byte_off, 3'b000};

  always_comb begin
    case (cur_size)
      core_pkg::size_byte: load_ext = {{24{load_raw[7] & cur_signed}}, load_raw[7:0]};
      core_pkg::size_half: load_ext = {{16{load_raw[15] & cur_signed}}, load_raw[15:0]};
      default: load_ext = load_raw;
    endcase
  end

  assign done_valid = state == st_hold;
  assign done_pc = cur_pc;
  assign done_rd = cur_rd;
  assign busy_rd = (state == st_idle) ? '0 : cur_rd;

  always_comb begin
    if (cur_ctrl == core_pkg::ctrl_jal || cur_ctrl == core_pkg::ctrl_jalr)
      done_data = cur_pc + 'd4; // link
    else if (cur_mem_kind == core_pkg::mem_load)
      done_data = load_val;
    else
      done_data = alu_res;
  end

  a_req_stable: assert property (@(posedge clock) disable iff (reset)
    mem_req && !mem_gnt |=> mem_req && $stable({mem_write, mem_addr, mem_wdata, mem_wstrb}));

  // memory answers only a granted request
  a_resp_expected: assert property (@(posedge clock) disable iff (reset)
    mem_resp_valid |-> state == st_response);

endmodule

`default_nettype wire

// ==== source/result_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module result_unit (
  input  wire logic clock,
  input  wire logic reset,
  input  wire logic done_valid,
  output logic done_ready,
  input  wire logic [core_pkg::xlen-1:0] done_pc,
  input  wire logic [core_pkg::reg_addr_w-1:0] done_rd,
  input  wire logic [core_pkg::xlen-1:0] done_data,
  output logic [core_pkg::reg_addr_w-1:0] pending_rd,
  output logic retire_valid,
  input  wire logic retire_ready,
  output logic [core_pkg::xlen-1:0] retire_pc,
  output logic [core_pkg::reg_addr_w-1:0] retire_rd,
  output logic [core_pkg::xlen-1:0] retire_data,
  input  wire logic [core_pkg::reg_addr_w-1:0] rs1_addr,
  input  wire logic [core_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [core_pkg::xlen-1:0] rs1_data,
  output logic [core_pkg::xlen-1:0] rs2_data
);

  logic [core_pkg::xlen-1:0] regs [core_pkg::reg_count];
  logic wr_en;

  assign done_ready = !retire_valid || retire_ready;
  assign pending_rd = retire_valid ? retire_rd : '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else if (done_valid && done_ready) begin
      retire_valid <= 1'b1;
    end else if (retire_ready) begin
      retire_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (done_valid && done_ready) begin
      retire_pc <= done_pc;
      retire_rd <= done_rd;
      retire_data <= done_data;
    end
  end

  // architectural write happens at retire
  assign wr_en = retire_valid && retire_ready && retire_rd != '0;

  always_ff @(posedge clock) begin
    if (wr_en) regs[retire_rd] <= retire_data;
  end

  always_comb begin
    if (rs1_addr == '0) rs1_data = '0;
    else if (wr_en && rs1_addr == retire_rd) rs1_data = retire_data; // write-through
    else rs1_data = regs[rs1_addr];
    if (rs2_addr == '0) rs2_data = '0;
    else if (wr_en && rs2_addr == retire_rd) rs2_data = retire_data;
    else rs2_data = regs[rs2_addr];
  end

endmodule

`default_nettype wire

// ==== source/exec_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_core (
  input  wire logic clock,
  input  wire logic reset,
  input  wire logic inst_valid,
  input  wire logic [core_pkg::xlen-1:0] inst_pc,
  input  wire logic [31:0] inst_word,
  output logic credit_return,
  output logic mem_req,
  input  wire logic mem_gnt,
  output logic mem_write,
  output logic [core_pkg::xlen-1:0] mem_addr,
  output logic [core_pkg::xlen-1:0] mem_wdata,
  output logic [core_pkg::xlen/8-1:0] mem_wstrb,
  input  wire logic mem_resp_valid,
  input  wire logic [core_pkg::xlen-1:0] mem_rdata,
  output logic retire_valid,
  input  wire logic retire_ready,
  output logic [core_pkg::xlen-1:0] retire_pc,
  output logic [core_pkg::reg_addr_w-1:0] retire_rd,
  output logic [core_pkg::xlen-1:0] retire_data
);

  logic [core_pkg::reg_addr_w-1:0] rs1_addr, rs2_addr, busy_rd, pending_rd, rd, done_rd;
  logic [core_pkg::xlen-1:0] rs1_data, rs2_data, pc, op_a, op_b, store_data, imm;
  logic [core_pkg::xlen-1:0] resolve_target, done_pc, done_data;
  logic issue_valid, issue_ready, alu_src_pc, alu_src_imm, mem_signed;
  logic resolve_valid, resolve_taken, done_valid, done_ready;
  logic [2:0] branch_cond;
  core_pkg::alu_op_t alu_op;
  core_pkg::mem_kind_t mem_kind;
  core_pkg::mem_size_t mem_size;
  core_pkg::ctrl_kind_t ctrl_kind;

  decode_unit u_decode (.*);

  execute_unit u_execute (.*);

  result_unit u_result (.*);

endmodule

`default_nettype wire

// ==== verif/exec_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_checker (
  input  wire logic clock,
  input  wire logic reset,
  input  wire logic inst_valid,
  input  wire logic [31:0] inst_pc,
  input  wire logic [31:0] inst_word,
  input  wire logic credit_return,
  input  wire logic retire_valid,
  input  wire logic retire_ready,
  input  wire logic [31:0] retire_pc,
  input  wire logic [4:0] retire_rd,
  input  wire logic [31:0] retire_data,
  output int tests_done,
  output int error_count,
  output int sent_count,
  output int returned_count
);

  logic [31:0] imem [1024];
  logic [31:0] smem [256];
  logic [31:0] sregs [32];
  logic [31:0] ref_pc;
  int credits, test_errors;

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] x, y);
    case (f3)
      3'd0: return alt ? x - y : x + y;
      3'd1: return x << y[4:0];
      3'd2: return {31'b0, $signed(x) < $signed(y)};
      3'd3: return {31'b0, x < y};
      3'd4: return x ^ y;
      3'd5: return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6: return x | y;
      default: return x & y;
    endcase
  endfunction

  // one architectural step on the shadow state
  function automatic void ref_step(input logic [31:0] pc, w, output logic [4:0] rd_o,
                                   output logic [31:0] data_o, output logic [31:0] next_o);
    logic [31:0] a, b, ii, is, ib, iu, ij, addr, lv;
    logic [2:0] f3;
    logic take;
    a = sregs[w[19:15]];
    b = sregs[w[24:20]];
    f3 = w[14:12];
    ii = {{20{w[31]}}, w[31:20]};
    is = {{20{w[31]}}, w[31:25], w[11:7]};
    ib = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    iu = {w[31:12], 12'b0};
    ij = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    rd_o = w[11:7];
    data_o = '0;
    next_o = pc + 4;
    case (w[6:0])
      core_pkg::op_lui: data_o = iu;
      core_pkg::op_auipc: data_o = pc + iu;
      core_pkg::op_jal: begin
        data_o = pc + 4;
        next_o = pc + ij;
      end
      core_pkg::op_jalr: begin
        data_o = pc + 4;
        next_o = (a + ii) & ~32'd1;
      end
      core_pkg::op_branch: begin
        rd_o = '0;
        case (f3)
          3'd0: take = a == b;
          3'd1: take = a != b;
          3'd4: take = $signed(a) < $signed(b);
          3'd5: take = $signed(a) >= $signed(b);
          3'd6: take = a < b;
          default: take = a >= b;
        endcase
        if (take) next_o = pc + ib;
      end
      core_pkg::op_load: begin
        addr = a + ii;
        lv = smem[addr[9:2]] >> (8 * addr[1:0]);
        case (f3)
          3'd0: data_o = {{24{lv[7]}}, lv[7:0]};
          3'd1: data_o = {{16{lv[15]}}, lv[15:0]};
          3'd4: data_o = {24'b0, lv[7:0]};
          3'd5: data_o = {16'b0, lv[15:0]};
          default: data_o = lv;
        endcase
      end
      core_pkg::op_store: begin
        rd_o = '0;
        addr = a + is;
        for (int k = 0; k < (1 << f3[1:0]); k++) begin
          smem[addr[9:2]][(int'(addr[1:0]) + k) * 8 +: 8] = b[k*8 +: 8];
        end
      end
      core_pkg::op_opimm: data_o = alu_ref(f3, f3 == 3'd5 && w[30], a, ii);
      core_pkg::op_op: data_o = alu_ref(f3, w[30], a, b);
      default: rd_o = '0;
    endcase
    if (rd_o != 0) sregs[rd_o] = data_o;
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) smem[i] = ((i * 4) * 32'h9e3779b1) ^ 32'hc3a50f96;
    for (int i = 0; i < 32; i++) sregs[i] = '0;
    ref_pc = '0;
    credits = core_pkg::inst_queue_depth;
    tests_done = 0;
    error_count = 0;
    sent_count = 0;
    returned_count = 0;
    test_errors = 0;
  end

  // sample between edges where all handshake signals are settled
  always @(negedge clock) begin
    logic [31:0] w, exp_data, exp_next;
    logic [4:0] exp_rd;
    if (!reset) begin
      if (inst_valid) begin
        imem[inst_pc[11:2]] = inst_word;
        sent_count++;
      end
      if (credit_return) returned_count++;
      credits = credits + (credit_return ? 1 : 0) - (inst_valid ? 1 : 0);
      if (credits > core_pkg::inst_queue_depth) begin
        $display("credit count %0d is above the queue depth", credits);
        error_count++;
        test_errors++;
      end
      if (retire_valid && retire_ready) begin
        w = imem[ref_pc[11:2]];
        ref_step(ref_pc, w, exp_rd, exp_data, exp_next);
        if (retire_pc !== ref_pc) begin
          $display("Mismatch retire_pc: got %h expected %h", retire_pc, ref_pc);
          error_count++;
          test_errors++;
        end
        if (retire_rd !== exp_rd) begin
          $display("Mismatch retire_rd: got %h expected %h", retire_rd, exp_rd);
          error_count++;
          test_errors++;
        end
        if (exp_rd != 0 && retire_data !== exp_data) begin
          $display("Mismatch retire_data: got %h expected %h at pc %h", retire_data,
                   exp_data, ref_pc);
          error_count++;
          test_errors++;
        end
        ref_pc = exp_next;
        if (w[6:0] == core_pkg::op_opimm && w[19:7] == '0 && w[31:20] != '0) begin
          $display("test %0d finished with %0d errors", w[31:20], test_errors);
          tests_done++;
          test_errors = 0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_exec_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_exec_core;

  localparam int num_tests = 5;
  localparam int mem_words = 256;

  logic clock = 1'b0;
  logic reset;
  logic inst_valid, mem_gnt, mem_resp_valid, retire_ready;
  logic [31:0] inst_pc, inst_word, mem_rdata;
  logic credit_return, mem_req, mem_write, retire_valid;
  logic [31:0] mem_addr, mem_wdata, retire_pc, retire_data;
  logic [3:0] mem_wstrb;
  logic [4:0] retire_rd;
  int tests_done, error_count, sent_count, returned_count;
  int seed, cycle, limit, spent, returned, send_idx, errors;
  bit sending;
  logic [31:0] prog_pc[$];
  logic [31:0] prog_word[$];
  logic [31:0] next_pc;
  logic [31:0] mem [mem_words];

  exec_core UUT (.*);
  exec_checker u_checker (.*);

  always #10 clock = ~clock;
  always @(posedge clock) cycle <= cycle + 1;

  function automatic logic [31:0] mem_fill(input int unsigned idx);
    return ((idx * 4) * 32'h9e3779b1) ^ 32'hc3a50f96;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, core_pkg::op_op};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], core_pkg::op_store};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], core_pkg::op_branch};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, core_pkg::op_jal};
  endfunction

  task automatic add_inst(input logic [31:0] word);
    prog_pc.push_back(next_pc);
    prog_word.push_back(word);
    next_pc = next_pc + 4;
  endtask

  task automatic add_random_op();
    logic [2:0] f3;
    logic [4:0] rd, rs1, rs2;
    logic [11:0] imm;
    logic alt;
    f3 = 3'({$random(seed)} % 8);
    rd = 5'(1 + {$random(seed)} % 8);
    rs1 = 5'(1 + {$random(seed)} % 8);
    rs2 = 5'(1 + {$random(seed)} % 8);
    alt = 1'({$random(seed)} % 2);
    imm = 12'($random(seed));
    if ({$random(seed)} % 2 == 0) begin
      add_inst(r_type((alt && (f3 == 0 || f3 == 5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
    end else begin
      if (f3 == 1) imm = {7'h00, imm[4:0]};
      if (f3 == 5) imm = {1'b0, alt, 5'h00, imm[4:0]}; // srai when alt
      add_inst(i_type(imm, rs1, f3, rd, core_pkg::op_opimm));
    end
  endtask

  task automatic add_marker(input int num);
    add_inst(i_type(12'(num), 5'd0, 3'd0, 5'd0, core_pkg::op_opimm)); // nop tagged with test
  endtask

  task automatic build_programs();
    next_pc = 0;
    for (int r = 1; r <= 8; r++) begin
      add_inst(u_type(20'($random(seed)), 5'(r), core_pkg::op_lui));
      add_inst(i_type(12'($random(seed)), 5'(r), 3'd0, 5'(r), core_pkg::op_opimm));
    end
    for (int k = 0; k < 14; k++) add_random_op();
    add_inst(u_type(20'h12345, 5'd8, core_pkg::op_auipc));
    add_marker(1);
    // loads and stores, base 0x100
    add_inst(i_type(12'h100, 5'd0, 3'd0, 5'd9, core_pkg::op_opimm));
    add_inst(s_type(12'd0, 5'd1, 5'd9, 3'd2));
    add_inst(s_type(12'd4, 5'd2, 5'd9, 3'd1));
    add_inst(s_type(12'd6, 5'd3, 5'd9, 3'd0));
    add_inst(s_type(12'd11, 5'd4, 5'd9, 3'd0));
    add_inst(i_type(12'd0, 5'd9, 3'd2, 5'd10, core_pkg::op_load));
    add_inst(i_type(12'd4, 5'd9, 3'd1, 5'd11, core_pkg::op_load));
    add_inst(i_type(12'd6, 5'd9, 3'd5, 5'd12, core_pkg::op_load));
    add_inst(i_type(12'd11, 5'd9, 3'd0, 5'd13, core_pkg::op_load));
    add_inst(i_type(12'd11, 5'd9, 3'd4, 5'd14, core_pkg::op_load));
    add_inst(i_type(12'd1, 5'd9, 3'd0, 5'd15, core_pkg::op_load));
    add_inst(i_type(12'd2, 5'd9, 3'd5, 5'd10, core_pkg::op_load));
    add_inst(i_type(12'd64, 5'd9, 3'd2, 5'd11, core_pkg::op_load));
    add_inst(i_type(12'd130, 5'd9, 3'd1, 5'd12, core_pkg::op_load));
    add_inst(i_type(12'd203, 5'd9, 3'd4, 5'd13, core_pkg::op_load));
    add_marker(2);
    // control flow, wrong-path pairs stay in the stream
    add_inst(b_type(13'd12, 5'd0, 5'd0, core_pkg::cond_beq));
    add_inst(i_type(12'd1, 5'd0, 3'd0, 5'd5, core_pkg::op_opimm));
    add_inst(i_type(12'd2, 5'd0, 3'd0, 5'd5, core_pkg::op_opimm));
    add_inst(b_type(13'd8, 5'd0, 5'd0, core_pkg::cond_bne));
    add_inst(b_type(13'd8, 5'd2, 5'd1, core_pkg::cond_blt));
    add_inst(i_type(12'd3, 5'd0, 3'd0, 5'd6, core_pkg::op_opimm));
    add_inst(j_type(21'd12, 5'd7));
    add_inst(i_type(12'd4, 5'd0, 3'd0, 5'd6, core_pkg::op_opimm));
    add_inst(i_type(12'd5, 5'd0, 3'd0, 5'd6, core_pkg::op_opimm));
    add_inst(u_type(20'h0, 5'd8, core_pkg::op_auipc));
    add_inst(i_type(12'd17, 5'd8, 3'd0, 5'd11, core_pkg::op_jalr)); // odd target
    for (int k = 0; k < 3; k++) add_inst(i_type(12'd6, 5'd0, 3'd0, 5'd6, core_pkg::op_opimm));
    add_inst(b_type(13'd8, 5'd2, 5'd1, core_pkg::cond_bgeu));
    add_inst(i_type(12'd7, 5'd0, 3'd0, 5'd10, core_pkg::op_opimm));
    add_inst(b_type(13'd8, 5'd2, 5'd1, core_pkg::cond_bltu));
    add_inst(i_type(12'd8, 5'd0, 3'd0, 5'd10, core_pkg::op_opimm));
    add_inst(b_type(13'd8, 5'd1, 5'd2, core_pkg::cond_bge));
    add_inst(i_type(12'd9, 5'd0, 3'd0, 5'd10, core_pkg::op_opimm));
    add_marker(3);
    // dependent chains and load-use
    add_inst(i_type(12'd5, 5'd0, 3'd0, 5'd1, core_pkg::op_opimm));
    add_inst(r_type(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
    add_inst(r_type(7'h20, 5'd1, 5'd2, 3'd0, 5'd3));
    add_inst(r_type(7'h00, 5'd1, 5'd3, 3'd1, 5'd4));
    add_inst(i_type(12'h100, 5'd0, 3'd0, 5'd9, core_pkg::op_opimm));
    add_inst(s_type(12'd8, 5'd4, 5'd9, 3'd2));
    add_inst(i_type(12'd8, 5'd9, 3'd2, 5'd5, core_pkg::op_load));
    add_inst(r_type(7'h00, 5'd5, 5'd5, 3'd0, 5'd6));
    add_inst(i_type(12'd8, 5'd9, 3'd2, 5'd7, core_pkg::op_load));
    add_inst(s_type(12'd12, 5'd7, 5'd9, 3'd2));
    add_inst(i_type(12'd12, 5'd9, 3'd2, 5'd8, core_pkg::op_load));
    add_inst(i_type(12'd1, 5'd8, 3'd0, 5'd8, core_pkg::op_opimm));
    add_marker(4);
    for (int k = 0; k < 20; k++) add_random_op();
    add_marker(5);
  endtask

  // credit_return is counted where it is stable
  always @(negedge clock) if (!reset && credit_return) returned <= returned + 1;

  // instruction source spends one credit per pair
  always @(posedge clock) begin
    #1;
    if (sending && send_idx < prog_pc.size() &&
        core_pkg::inst_queue_depth + returned - spent > 0) begin
      inst_valid = 1'b1;
      inst_pc = prog_pc[send_idx];
      inst_word = prog_word[send_idx];
      send_idx++;
      spent++;
    end else begin
      inst_valid = 1'b0;
    end
  end

  always @(posedge clock) begin
    #1 retire_ready = ({$random(seed)} % 3) != 0;
  end

  // data memory with random grant and response delay
  initial begin
    int d;
    int idx;
    forever begin
      @(negedge clock);
      if (mem_req) begin
        @(posedge clock);
        d = {$random(seed)} % 5;
        repeat (d) @(posedge clock);
        #1 mem_gnt = 1'b1;
        idx = int'(mem_addr[9:2]);
        for (int b = 0; b < 4; b++) begin
          if (mem_write && mem_wstrb[b]) mem[idx][b*8 +: 8] = mem_wdata[b*8 +: 8];
        end
        @(posedge clock);
        d = {$random(seed)} % 5;
        #1 mem_gnt = 1'b0;
        repeat (d) begin
          @(posedge clock);
          #1;
        end
        mem_rdata = mem[idx];
        mem_resp_valid = 1'b1;
        @(posedge clock);
        #1 mem_resp_valid = 1'b0;
      end
    end
  end

  initial begin
    reset = 1'b1;
    inst_valid = 1'b0;
    inst_pc = '0;
    inst_word = '0;
    mem_gnt = 1'b0;
    mem_resp_valid = 1'b0;
    mem_rdata = '0;
    retire_ready = 1'b0;
    sending = 1'b0;
    cycle = 0;
    spent = 0;
    returned = 0;
    send_idx = 0;
    errors = 0;
    seed = 58;
    for (int i = 0; i < mem_words; i++) mem[i] = mem_fill(i);
    build_programs();
    limit = prog_pc.size() * 40 + 100;
    repeat (10) @(posedge clock);
    sending = 1'b1;
    #1 reset = 1'b0;
    while (tests_done < num_tests && cycle < limit) @(posedge clock);
    if (cycle >= limit) begin
      $display("timeout after %0d cycles with %0d of %0d tests done", cycle, tests_done,
               num_tests);
      $display("Test failed");
    end else begin
      if (returned_count != sent_count || sent_count != prog_pc.size()) begin
        $display("credits returned %0d, pairs sent %0d, program has %0d pairs",
                 returned_count, sent_count, prog_pc.size());
        errors++;
      end
      $display("tests run %0d, errors %0d", tests_done, error_count + errors);
      if (error_count + errors == 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
source/core_pkg.sv
source/alu.sv
source/decode_unit.sv
source/execute_unit.sv
source/result_unit.sv
source/exec_core.sv
verif/exec_checker.sv
verif/tb_exec_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run with Verilator, pass only if the pass line is printed
out=$(verilator --binary --timing --assert -Wno-fatal --top-module tb_exec_core \
    -f flist.f -o sim_exec_core && ./obj_dir/sim_exec_core) || {
  echo "$out"
  echo "build or simulation error"
  exit 1
}
echo "$out"
echo "$out" | grep -q "Test completed successfully" && exit 0 || exit 1
